// File: rtl/core_pkg.sv
package core_pkg;

	parameter int xlen = 64;

	typedef logic [xlen-1:0] addr_t;
	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	parameter logic [6:0] op_lui = 7'h37;
	parameter logic [6:0] op_imm = 7'h13;
	parameter logic [6:0] op_reg = 7'h33;
	parameter logic [6:0] op_trap = 7'h6b; // ends the run, code in x[rs1]

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t rs1;
		logic [2:0] funct3;
		reg_idx_t rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef union packed {
		logic [31:0] raw; // lui takes raw[31:12]
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} insn_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		insn_t insn;
		alu_op_t alu_op;
		word_t operand_a;
		word_t operand_b;
		reg_idx_t rd;
		logic we;
		logic is_trap;
	} ex_req_t;

	// write-back port and committed record share this layout
	typedef struct packed {
		logic valid;
		addr_t pc;
		insn_t insn;
		logic we;
		reg_idx_t rd;
		word_t data;
	} commit_t;

	typedef struct packed {
		logic valid;
		logic [7:0] code;
		logic [63:0] cycle_cnt;
		logic [63:0] instr_cnt;
	} trap_t;

endpackage

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_pkg::addr_t reset_pc = 64'h0000_0000_8000_0000
) (
	input logic clock,
	input logic reset,
	input logic halt,
	input logic [31:0] ibus_dat,
	input logic ibus_ack,
	output core_pkg::addr_t ibus_adr,
	output logic ibus_cyc,
	output logic ibus_stb,
	output logic fetch_valid,
	output core_pkg::addr_t fetch_pc,
	output core_pkg::insn_t fetch_insn
);
	import core_pkg::*;

	addr_t pc;
	logic cyc;

	assign ibus_adr = pc;
	assign ibus_cyc = cyc;
	assign ibus_stb = cyc; // single-beat reads, stb follows cyc

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
			cyc <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b0;
			if (cyc && ibus_ack) begin
				cyc <= 1'b0; // idle at least one cycle
				pc <= pc + 64'd4;
				fetch_valid <= 1'b1;
			end else if (!cyc && !halt) begin
				cyc <= 1'b1;
			end
		end
	end

	// word and its address, taken at the ack edge
	always_ff @(posedge clock) begin
		if (cyc && ibus_ack) begin
			fetch_pc <= pc;
			fetch_insn <= ibus_dat;
		end
	end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clock,
	input logic reset,
	input core_pkg::reg_idx_t rs1_idx,
	input core_pkg::reg_idx_t rs2_idx,
	input core_pkg::commit_t wb,
	output core_pkg::word_t rs1_data,
	output core_pkg::word_t rs2_data
);
	import core_pkg::*;

	word_t regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wb.valid && wb.we && wb.rd != 5'd0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic reset,
	input logic fetch_valid,
	input core_pkg::addr_t fetch_pc,
	input core_pkg::insn_t fetch_insn,
	input core_pkg::word_t rs1_data,
	input core_pkg::word_t rs2_data,
	input core_pkg::commit_t ex_fwd,
	input core_pkg::commit_t wb,
	output core_pkg::reg_idx_t rs1_idx,
	output core_pkg::reg_idx_t rs2_idx,
	output logic halt,
	output core_pkg::ex_req_t ex_req
);
	import core_pkg::*;

	ex_req_t req_next;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm_i;
	word_t imm_u;

	// youngest producer wins
	function automatic word_t fwd(reg_idx_t idx, word_t rf_data);
		if (idx == 5'd0)
			return '0;
		if (ex_fwd.valid && ex_fwd.we && ex_fwd.rd == idx)
			return ex_fwd.data;
		if (wb.valid && wb.we && wb.rd == idx)
			return wb.data;
		return rf_data;
	endfunction

	assign rs1_idx = fetch_insn.i_fmt.rs1;
	assign rs2_idx = fetch_insn.r_fmt.rs2;
	assign rs1_val = fwd(rs1_idx, rs1_data);
	assign rs2_val = fwd(rs2_idx, rs2_data);

	assign imm_i = {{52{fetch_insn.i_fmt.imm[11]}}, fetch_insn.i_fmt.imm};
	assign imm_u = {{32{fetch_insn.raw[31]}}, fetch_insn.raw[31:12], 12'h000};

	always_comb begin
		req_next.valid = fetch_valid && !halt; // drop words fetched past the trap
		req_next.pc = fetch_pc;
		req_next.insn = fetch_insn;
		req_next.rd = fetch_insn.r_fmt.rd;
		req_next.operand_a = rs1_val;
		req_next.operand_b = rs2_val;
		req_next.alu_op = alu_add;
		req_next.we = 1'b0;
		req_next.is_trap = 1'b0;
		case (fetch_insn.r_fmt.opcode)
			op_reg: begin
				req_next.we = 1'b1;
				case ({fetch_insn.r_fmt.funct7, fetch_insn.r_fmt.funct3})
					{7'h00, 3'd0}: req_next.alu_op = alu_add;
					{7'h20, 3'd0}: req_next.alu_op = alu_sub;
					{7'h00, 3'd4}: req_next.alu_op = alu_xor;
					{7'h00, 3'd6}: req_next.alu_op = alu_or;
					{7'h00, 3'd7}: req_next.alu_op = alu_and;
					default: req_next.we = 1'b0; // unsupported, no-op
				endcase
			end
			op_imm: begin
				req_next.we = 1'b1;
				req_next.operand_b = imm_i;
				case (fetch_insn.i_fmt.funct3)
					3'd0: req_next.alu_op = alu_add;
					3'd4: req_next.alu_op = alu_xor;
					3'd6: req_next.alu_op = alu_or;
					3'd7: req_next.alu_op = alu_and;
					default: req_next.we = 1'b0;
				endcase
			end
			op_lui: begin
				req_next.we = 1'b1;
				req_next.alu_op = alu_pass_b;
				req_next.operand_b = imm_u;
			end
			op_trap: req_next.is_trap = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_req.valid <= 1'b0;
			halt <= 1'b0;
		end else begin
			ex_req <= req_next;
			if (req_next.valid && req_next.is_trap)
				halt <= 1'b1; // sticky until reset
		end
	end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input logic clock,
	input logic reset,
	input core_pkg::ex_req_t ex_req,
	output core_pkg::commit_t ex_fwd,
	output core_pkg::commit_t wb,
	output logic wb_is_trap
);
	import core_pkg::*;

	word_t result;

	always_comb begin
		case (ex_req.alu_op)
			alu_add: result = ex_req.operand_a + ex_req.operand_b;
			alu_sub: result = ex_req.operand_a - ex_req.operand_b;
			alu_and: result = ex_req.operand_a & ex_req.operand_b;
			alu_or: result = ex_req.operand_a | ex_req.operand_b;
			alu_xor: result = ex_req.operand_a ^ ex_req.operand_b;
			alu_pass_b: result = ex_req.operand_b;
			default: result = '0;
		endcase
		if (ex_req.is_trap)
			result = ex_req.operand_a; // carries x[rs1] to the trap code
	end

	always_comb begin
		ex_fwd.valid = ex_req.valid;
		ex_fwd.pc = ex_req.pc;
		ex_fwd.insn = ex_req.insn;
		ex_fwd.we = ex_req.we;
		ex_fwd.rd = ex_req.rd;
		ex_fwd.data = (ex_req.we && ex_req.rd == 5'd0) ? '0 : result; // x0 stays zero
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb.valid <= 1'b0;
			wb_is_trap <= 1'b0;
		end else begin
			wb <= ex_fwd;
			wb_is_trap <= ex_req.valid && ex_req.is_trap;
		end
	end

endmodule

// File: rtl/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
	input logic clock,
	input logic reset,
	input core_pkg::commit_t wb,
	input logic wb_is_trap,
	output core_pkg::commit_t commit,
	output core_pkg::trap_t trap
);

	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
			trap <= '0;
		end else if (!trap.valid) begin
			commit <= wb;
			trap.cycle_cnt <= trap.cycle_cnt + 64'd1; // includes the trap edge
			if (wb.valid)
				trap.instr_cnt <= trap.instr_cnt + 64'd1;
			if (wb.valid && wb_is_trap) begin
				trap.valid <= 1'b1;
				trap.code <= wb.data[7:0];
			end
		end else begin
			commit.valid <= 1'b0; // frozen after trap
		end
	end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
	parameter core_pkg::addr_t reset_pc = 64'h0000_0000_8000_0000
) (
	input logic clock,
	input logic reset,
	output core_pkg::addr_t ibus_adr,
	output logic ibus_cyc,
	output logic ibus_stb,
	input logic [31:0] ibus_dat,
	input logic ibus_ack,
	output core_pkg::commit_t commit,
	output core_pkg::trap_t trap
);
	import core_pkg::*;

	logic halt;
	logic fetch_valid;
	addr_t fetch_pc;
	insn_t fetch_insn;
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	word_t rs1_data;
	word_t rs2_data;
	ex_req_t ex_req;
	commit_t ex_fwd;
	commit_t wb;
	logic wb_is_trap;

	fetch_unit #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clock(clock),
		.reset(reset),
		.halt(halt),
		.ibus_dat(ibus_dat),
		.ibus_ack(ibus_ack),
		.ibus_adr(ibus_adr),
		.ibus_cyc(ibus_cyc),
		.ibus_stb(ibus_stb),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_insn(fetch_insn)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_insn(fetch_insn),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex_fwd(ex_fwd),
		.wb(wb),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.halt(halt),
		.ex_req(ex_req)
	);

	reg_file u_regs (
		.clock(clock),
		.reset(reset),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.wb(wb),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	execute_stage u_execute (
		.clock(clock),
		.reset(reset),
		.ex_req(ex_req),
		.ex_fwd(ex_fwd),
		.wb(wb),
		.wb_is_trap(wb_is_trap)
	);

	commit_unit u_commit (
		.clock(clock),
		.reset(reset),
		.wb(wb),
		.wb_is_trap(wb_is_trap),
		.commit(commit),
		.trap(trap)
	);

endmodule

// File: dv/core_chk.sv
`timescale 1ns/1ps

module core_chk (
	input logic clock,
	input logic reset,
	input logic ibus_cyc,
	input logic ibus_stb,
	input logic ibus_ack,
	input core_pkg::addr_t ibus_adr,
	input core_pkg::commit_t commit,
	input core_pkg::trap_t trap
);

	stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
		ibus_stb |-> ibus_cyc)
		else $error("ibus stb high outside a bus cycle");

	// address held until the slave acks
	adr_stable: assert property (@(posedge clock) disable iff (reset)
		(ibus_stb && !ibus_ack) |=> $stable(ibus_adr))
		else $error("ibus address changed while waiting for ack");

	no_commit_after_trap: assert property (@(posedge clock) disable iff (reset)
		trap.valid |=> !commit.valid)
		else $error("commit reported after trap");

endmodule

// File: dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;
	import core_pkg::*;

	localparam addr_t reset_pc = 64'h0000_0000_8000_0000;
	localparam int mem_words = 64;
	localparam int trap_timeout = 2000;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic ibus_ack = 1'b0;
	logic [31:0] ibus_dat = '0;
	addr_t ibus_adr;
	logic ibus_cyc;
	logic ibus_stb;
	commit_t commit;
	trap_t trap;

	logic [31:0] mem [mem_words];
	logic [31:0] prog [$];
	commit_t expected [$];
	commit_t got [$];
	int unsigned latency [256];
	logic [7:0] exp_code;
	trap_t exp_trap;
	logic zero_wait = 1'b0;
	logic trap_seen = 1'b0;
	int wait_left = -1;
	int lat_pos = 0;
	int edge_cnt = 0;
	int trap_edge = 0;
	int errors = 0;

	always #5 clock = ~clock;

	rv_core #(
		.reset_pc(reset_pc)
	) dut (
		.clock(clock),
		.reset(reset),
		.ibus_adr(ibus_adr),
		.ibus_cyc(ibus_cyc),
		.ibus_stb(ibus_stb),
		.ibus_dat(ibus_dat),
		.ibus_ack(ibus_ack),
		.commit(commit),
		.trap(trap)
	);

	bind rv_core core_chk chk (
		.clock(clock),
		.reset(reset),
		.ibus_cyc(ibus_cyc),
		.ibus_stb(ibus_stb),
		.ibus_ack(ibus_ack),
		.ibus_adr(ibus_adr),
		.commit(commit),
		.trap(trap)
	);

	function automatic logic [31:0] fill_word(addr_t adr);
		logic [31:0] folded;
		folded = adr[31:0] ^ adr[63:32];
		return {folded[31:7], 7'h0b}; // custom-0 opcode is a no-op in this core
	endfunction

	function automatic logic [31:0] read_word(addr_t adr);
		addr_t offset;
		offset = (adr - reset_pc) >> 2;
		if (offset < 64'(mem_words))
			return mem[offset[5:0]];
		return fill_word(adr);
	endfunction

	function automatic logic [31:0] r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
			reg_idx_t rd);
		return {imm, rs1, f3, rd, op_imm};
	endfunction

	function automatic logic [31:0] lui_word(logic [19:0] imm, reg_idx_t rd);
		return {imm, rd, op_lui};
	endfunction

	function automatic logic [31:0] trap_word(reg_idx_t rs1);
		return {12'h000, rs1, 3'h0, 5'h00, op_trap};
	endfunction

	// wishbone slave acks each read after 0..3 wait states
	always @(posedge clock) begin
		#1;
		if (reset || ibus_ack || !ibus_stb) begin
			ibus_ack = 1'b0;
			wait_left = -1;
		end else begin
			if (wait_left < 0) begin
				wait_left = zero_wait ? 0 : int'(latency[lat_pos % 256]);
				lat_pos++;
			end
			if (wait_left == 0) begin
				ibus_dat = read_word(ibus_adr);
				ibus_ack = 1'b1;
			end
			wait_left--;
		end
	end

	always @(posedge clock) begin
		if (reset)
			edge_cnt = 0;
		else
			edge_cnt++;
	end

	always @(negedge clock) begin
		if (reset) begin
			got.delete();
			trap_seen = 1'b0;
		end else begin
			if (commit.valid)
				got.push_back(commit);
			if (trap.valid && !trap_seen) begin
				trap_seen = 1'b1;
				trap_edge = edge_cnt; // includes the edge that raised trap
			end
		end
	end

	task automatic apply_reset();
		@(posedge clock);
		#1;
		reset = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic load_program();
		for (int i = 0; i < mem_words; i++)
			mem[i] = (i < prog.size()) ? prog[i] : fill_word(reset_pc + addr_t'(4 * i));
	endtask

	// architectural model in program order up to the first trap
	task automatic build_expected();
		word_t x [32];
		commit_t c;
		logic [31:0] w;
		word_t a;
		word_t b;
		word_t imm;
		x = '{default: '0};
		expected.delete();
		foreach (prog[i]) begin
			w = prog[i];
			a = x[w[19:15]];
			b = x[w[24:20]];
			imm = {{52{w[31]}}, w[31:20]};
			c = '0;
			c.valid = 1'b1;
			c.pc = reset_pc + addr_t'(4 * i);
			c.insn = w;
			c.rd = w[11:7];
			c.we = 1'b1;
			case (w[6:0])
				op_reg: begin
					case ({w[31:25], w[14:12]})
						{7'h00, 3'd0}: c.data = a + b;
						{7'h20, 3'd0}: c.data = a - b;
						{7'h00, 3'd4}: c.data = a ^ b;
						{7'h00, 3'd6}: c.data = a | b;
						{7'h00, 3'd7}: c.data = a & b;
						default: c.we = 1'b0;
					endcase
				end
				op_imm: begin
					case (w[14:12])
						3'd0: c.data = a + imm;
						3'd4: c.data = a ^ imm;
						3'd6: c.data = a | imm;
						3'd7: c.data = a & imm;
						default: c.we = 1'b0;
					endcase
				end
				op_lui: c.data = {{32{w[31]}}, w[31:12], 12'h000};
				op_trap: begin
					c.we = 1'b0;
					c.data = a;
				end
				default: c.we = 1'b0;
			endcase
			if (c.we && c.rd == 5'd0)
				c.data = '0; // x0 reads as zero
			if (c.we)
				x[c.rd] = c.data;
			expected.push_back(c);
			if (w[6:0] == op_trap) begin
				exp_code = a[7:0];
				break;
			end
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			errors++;
			$display("FAILED %s: commit count expected %0d, got %0d", name, exp, act);
		end
	endtask

	task automatic check_commit(string name, commit_t exp, commit_t act);
		if (act.valid !== exp.valid || act.pc !== exp.pc || act.insn !== exp.insn ||
				act.we !== exp.we || act.rd !== exp.rd ||
				(exp.we && act.data !== exp.data)) begin
			errors++;
			$write("FAILED %s: commit expected pc=%h insn=%h we=%b rd=%0d data=%h",
				name, exp.pc, exp.insn, exp.we, exp.rd, exp.data);
			$display(", got pc=%h insn=%h we=%b rd=%0d data=%h",
				act.pc, act.insn, act.we, act.rd, act.data);
		end
	endtask

	task automatic check_trap(string name, trap_t exp, trap_t act);
		if (act !== exp) begin
			errors++;
			$write("FAILED %s: trap expected valid=%b code=%h cycles=%0d instrs=%0d",
				name, exp.valid, exp.code, exp.cycle_cnt, exp.instr_cnt);
			$display(", got valid=%b code=%h cycles=%0d instrs=%0d",
				act.valid, act.code, act.cycle_cnt, act.instr_cnt);
		end
	endtask

	task automatic run_program(string name);
		int cycles;
		load_program();
		build_expected();
		apply_reset();
		cycles = 0;
		while (!trap_seen && cycles < trap_timeout) begin
			@(posedge clock);
			cycles++;
		end
		#1;
		exp_trap.valid = 1'b1;
		exp_trap.code = exp_code;
		exp_trap.cycle_cnt = 64'(trap_edge);
		exp_trap.instr_cnt = 64'(expected.size());
		if (!trap_seen) begin
			errors++;
			$display("%s: trap never raised within %0d cycles", name, trap_timeout);
			return;
		end
		check_count(name, expected.size(), got.size());
		foreach (expected[i])
			if (i < got.size())
				check_commit(name, expected[i], got[i]);
		check_trap(name, exp_trap, trap);
	endtask

	task automatic alu_ops();
		prog.delete();
		prog.push_back(lui_word(20'h12345, 5'd1));
		prog.push_back(i_type(12'h678, 5'd1, 3'd0, 5'd1));
		prog.push_back(lui_word(20'hfedcb, 5'd2)); // upper bit set so the value sign extends
		prog.push_back(i_type(12'h9a1, 5'd2, 3'd0, 5'd2));
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
		prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd5));
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
		prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd7));
		prog.push_back(i_type(12'hfff, 5'd1, 3'd0, 5'd8));
		prog.push_back(i_type(12'h0f0, 5'd2, 3'd7, 5'd9));
		prog.push_back(i_type(12'h800, 5'd1, 3'd6, 5'd10));
		prog.push_back(i_type(12'h555, 5'd2, 3'd4, 5'd11));
		prog.push_back(trap_word(5'd7));
		run_program("alu_ops");
	endtask

	task automatic forwarding_chain();
		zero_wait = 1'b1;
		prog.delete();
		prog.push_back(i_type(12'h001, 5'd0, 3'd0, 5'd1));
		prog.push_back(i_type(12'h001, 5'd1, 3'd0, 5'd1));
		prog.push_back(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
		prog.push_back(i_type(12'h003, 5'd2, 3'd0, 5'd2));
		prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
		prog.push_back(r_type(7'h00, 5'd3, 5'd3, 3'd0, 5'd3));
		prog.push_back(r_type(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
		prog.push_back(trap_word(5'd4));
		run_program("forwarding");
		zero_wait = 1'b0;
	endtask

	task automatic commit_order();
		prog.delete();
		prog.push_back(i_type(12'h007, 5'd0, 3'd0, 5'd5));
		prog.push_back(i_type(12'h005, 5'd0, 3'd0, 5'd0)); // write to x0
		prog.push_back(32'h0011_0f8b); // unknown opcode with rd = 31
		prog.push_back(r_type(7'h00, 5'd0, 5'd5, 3'd0, 5'd6));
		prog.push_back(lui_word(20'habcde, 5'd0));
		prog.push_back(trap_word(5'd6));
		run_program("commit_order");
	endtask

	task automatic trap_code();
		prog.delete();
		prog.push_back(i_type(12'h02a, 5'd0, 3'd0, 5'd10));
		prog.push_back(i_type(12'h7ff, 5'd0, 3'd0, 5'd11));
		prog.push_back(trap_word(5'd10));
		run_program("trap_code");
		if (trap.code !== 8'h2a) begin
			errors++;
			$display("FAILED trap_code: code expected 2a, got %h", trap.code);
		end
	endtask

	task automatic halt_after_trap();
		prog.delete();
		prog.push_back(i_type(12'h001, 5'd0, 3'd0, 5'd1));
		prog.push_back(i_type(12'h002, 5'd0, 3'd0, 5'd2));
		prog.push_back(trap_word(5'd2));
		prog.push_back(i_type(12'h003, 5'd0, 3'd0, 5'd3)); // must never commit
		prog.push_back(i_type(12'h004, 5'd0, 3'd0, 5'd4));
		prog.push_back(trap_word(5'd1));
		run_program("halt");
		repeat (20) begin
			@(posedge clock);
			#1;
			check_trap("halt", exp_trap, trap);
		end
		check_count("halt", expected.size(), got.size());
	endtask

	initial begin
		void'($urandom(54));
		foreach (latency[i])
			latency[i] = $urandom % 4;
		alu_ops();
		forwarding_chain();
		commit_order();
		trap_code();
		halt_after_trap();
		$display("tests done, errors: %0d", errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sources.f
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/commit_unit.sv
rtl/rv_core.sv
dv/core_chk.sv
dv/core_tb.sv

// File: Makefile
SRCS := $(shell cat sources.f)

obj_dir/Vcore_tb: sources.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module core_tb -f sources.f

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

.PHONY: run clean
